/* src/div_pkg.sv */
`default_nettype none

package div_pkg;

	// ####################
	// datapath widths
	// ####################

	// operand and result width
	localparam int DATA_W = 32;
	// request tag carried alongside each operation
	localparam int TAG_W = 4;
	localparam int OP_W = 2;

	// ####################
	// operation codes
	// ####################

	// bit 0 set means unsigned operands
	// bit 1 set means the remainder is returned instead of the quotient
	localparam logic [OP_W-1:0] OP_DIV = 2'b00;
	localparam logic [OP_W-1:0] OP_DIVU = 2'b01;
	localparam logic [OP_W-1:0] OP_REM = 2'b10;
	localparam logic [OP_W-1:0] OP_REMU = 2'b11;

	// ####################
	// divider stepping
	// ####################

	// step counter wide enough to hold the step count itself
	localparam int STEP_CNT_W = 5;
	// two quotient bits retired per advance
	localparam logic [STEP_CNT_W-1:0] DIV_STEPS = STEP_CNT_W'(DATA_W / 2);

endpackage

`default_nettype wire

/* src/credit_pkg.sv */
`default_nettype none

package credit_pkg;

	// request channel
	// queue pointer, the queue holds a power of two entries
	localparam int REQ_PTR_W = 2;
	// entries in the queue, also the credits the sender owns after reset
	// one bit wider than the pointer so a full queue can be counted
	localparam logic [REQ_PTR_W:0] REQ_DEPTH = 3'd4;

	// result channel
	localparam int RESULT_CNT_W = 2;
	// result slots the consumer grants after reset
	localparam logic [RESULT_CNT_W-1:0] RESULT_CREDITS = 2'd2;

endpackage

`default_nettype wire

/* src/div_req_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module div_req_queue (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              req_valid,
	input  logic [div_pkg::OP_W-1:0]          req_op,
	input  logic [div_pkg::TAG_W-1:0]         req_tag,
	input  logic [div_pkg::DATA_W-1:0]        req_dividend,
	input  logic [div_pkg::DATA_W-1:0]        req_divisor,
	input  logic                              q_pop,
	output logic                              req_credit,
	output logic                              q_valid,
	output logic [div_pkg::OP_W-1:0]          q_op,
	output logic [div_pkg::TAG_W-1:0]         q_tag,
	output logic [div_pkg::DATA_W-1:0]        q_dividend,
	output logic [div_pkg::DATA_W-1:0]        q_divisor
);

	// entry storage, one array per field
	logic [div_pkg::OP_W-1:0] op_mem [0:credit_pkg::REQ_DEPTH-1];
	logic [div_pkg::TAG_W-1:0] tag_mem [0:credit_pkg::REQ_DEPTH-1];
	logic [div_pkg::DATA_W-1:0] dividend_mem [0:credit_pkg::REQ_DEPTH-1];
	logic [div_pkg::DATA_W-1:0] divisor_mem [0:credit_pkg::REQ_DEPTH-1];

	logic [credit_pkg::REQ_PTR_W-1:0] wr_ptr;
	logic [credit_pkg::REQ_PTR_W-1:0] rd_ptr;
	// occupancy, one bit wider than the pointers
	logic [credit_pkg::REQ_PTR_W:0] count;
	logic pop;

	// ####################
	// head and pop
	// ####################

	assign q_valid = (count != '0);
	// a pop on an empty queue is ignored
	assign pop = q_pop & q_valid;

	// head entry is read straight out of the array
	assign q_op = op_mem[rd_ptr];
	assign q_tag = tag_mem[rd_ptr];
	assign q_dividend = dividend_mem[rd_ptr];
	assign q_divisor = divisor_mem[rd_ptr];

	// ####################
	// storage write
	// ####################

	// the sender only sends on a credit, so every request is written
	always_ff @(posedge clk) begin
		if (req_valid) begin
			op_mem[wr_ptr] <= req_op;
			tag_mem[wr_ptr] <= req_tag;
			dividend_mem[wr_ptr] <= req_dividend;
			divisor_mem[wr_ptr] <= req_divisor;
		end
	end

	// ####################
	// pointers and credits
	// ####################

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			req_credit <= 1'b0;
		end else begin
			// pointers wrap on their own at the queue depth
			if (req_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// push and pop together leave the count alone
			case ({req_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// freed entry goes back to the sender one cycle later
			req_credit <= pop;
		end
	end

endmodule

`default_nettype wire

/* src/div_radix4_core.sv */
`timescale 1ns/1ns
`default_nettype none

module div_radix4_core (
	input  logic                       clk,
	input  logic [div_pkg::DATA_W-1:0] dividend,
	input  logic [div_pkg::DATA_W-1:0] divisor,
	input  logic                       unsign,
	input  logic                       d_init,
	input  logic                       e_advance,
	output logic [div_pkg::DATA_W-1:0] quot,
	output logic [div_pkg::DATA_W-1:0] remd
);

	logic sign_divisor;
	logic sign_dividend;
	logic sign_dvs;
	logic sign_dvd;
	logic sign_quot;
	logic [div_pkg::DATA_W-1:0] dvs;
	// dividend, quotient bits shift in from the right
	logic [div_pkg::DATA_W-1:0] dvd;
	// partial remainder with three guard bits
	logic [div_pkg::DATA_W+2:0] rem;
	logic [div_pkg::DATA_W+2:0] rem_shift;
	logic [div_pkg::DATA_W+2:0] rem_next;
	logic sub;
	logic [div_pkg::DATA_W+2:0] dvs_ivt;
	logic [div_pkg::DATA_W+2:0] dvs_x2;
	logic [div_pkg::DATA_W+2:0] rem_sub1;
	logic [div_pkg::DATA_W+2:0] rem_sub2;
	logic [div_pkg::DATA_W+2:0] rem_sub3;
	logic [div_pkg::DATA_W+2:0] sub3_ps;
	logic [div_pkg::DATA_W+2:0] sub3_pc;
	logic sign_rem1;
	logic sign_rem2;
	logic sign_rem3;
	logic quot_1;
	logic quot_0;

	// ####################
	// operand latch
	// ####################

	// signs only count for signed operations
	assign sign_divisor = divisor[div_pkg::DATA_W-1] & ~unsign;
	assign sign_dividend = dividend[div_pkg::DATA_W-1] & ~unsign;

	always_ff @(posedge clk) begin
		if (d_init) begin
			dvs <= divisor;
			sign_dvs <= sign_divisor;
			sign_dvd <= sign_dividend;
			sign_quot <= sign_divisor ^ sign_dividend;
		end
	end

	// ####################
	// trial subtraction
	// ####################

	// next two dividend bits enter the remainder
	assign rem_shift = {rem[div_pkg::DATA_W:0], dvd[div_pkg::DATA_W-1 -: 2]};

	// subtract when signs agree, add when the quotient goes negative
	// this follows the dividend sign, so a zero remainder keeps the direction
	assign sub = ~sign_quot;
	// inverted divisor, the +1 of two's complement enters as carry-in
	assign dvs_ivt = {(div_pkg::DATA_W+3){sub}} ^ {{3{sign_dvs}}, dvs};
	// twice the divisor, the low bit completes the inversion of the shifted term
	assign dvs_x2 = {dvs_ivt[div_pkg::DATA_W+1:0], sub};

	// one and two times the divisor
	assign rem_sub1 = rem_shift + dvs_ivt + {{(div_pkg::DATA_W+2){1'b0}}, sub};
	assign rem_sub2 = rem_shift + dvs_x2 + {{(div_pkg::DATA_W+2){1'b0}}, sub};

	// three times the divisor, carry-save compress then carry-propagate add
	assign sub3_ps = rem_shift ^ dvs_x2 ^ dvs_ivt;
	assign sub3_pc = (rem_shift & dvs_x2) | (rem_shift & dvs_ivt) | (dvs_x2 & dvs_ivt);
	// carry vector shifts up, freed low bit and carry-in each add one
	assign rem_sub3 = sub3_ps + {sub3_pc[div_pkg::DATA_W+1:0], sub}
		+ {{(div_pkg::DATA_W+2){1'b0}}, sub};

	// ####################
	// digit selection
	// ####################

	// a trial overshoots when its sign departs from the dividend sign
	// a negative dividend runs one low, so its zero trial is really one and overshoots
	assign sign_rem1 = rem_sub1[div_pkg::DATA_W+2] ^ sign_dvd;
	assign sign_rem2 = rem_sub2[div_pkg::DATA_W+2] ^ sign_dvd;
	assign sign_rem3 = rem_sub3[div_pkg::DATA_W+2] ^ sign_dvd;

	// digit 0..3 from the overshoot pattern
	// inverted for a negative quotient, giving one's complement
	assign quot_1 = ~sign_rem2 ^ sign_quot;
	assign quot_0 = ((~sign_rem1 & sign_rem2) | ~sign_rem3) ^ sign_quot;

	// keep the largest trial that did not overshoot
	always_comb begin
		if (sign_rem1)
			rem_next = rem_shift;
		else if (sign_rem2)
			rem_next = rem_sub1;
		else if (sign_rem3)
			rem_next = rem_sub2;
		else
			rem_next = rem_sub3;
	end

	// ####################
	// state update
	// ####################

	always_ff @(posedge clk) begin
		if (d_init) begin
			// negative dividend enters one low
			// its partial remainders then sit one below the truncated ones
			dvd <= dividend - {{(div_pkg::DATA_W-1){1'b0}}, sign_dividend};
			// sign extension of the dividend seeds the remainder
			rem <= {(div_pkg::DATA_W+3){sign_dividend}};
		end else if (e_advance) begin
			dvd <= {dvd[div_pkg::DATA_W-3:0], quot_1, quot_0};
			rem <= rem_next;
		end
	end

	// one's complement quotient becomes two's complement here
	assign quot = dvd + {{(div_pkg::DATA_W-1){1'b0}}, sign_quot};
	// remainder carries the dividend sign
	// a negative one gets back the one it ran low
	assign remd = rem[div_pkg::DATA_W-1:0] + {{(div_pkg::DATA_W-1){1'b0}}, sign_dvd};

endmodule

`default_nettype wire

/* src/div_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module div_sequencer (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        q_valid,
	input  logic [div_pkg::OP_W-1:0]    q_op,
	input  logic [div_pkg::TAG_W-1:0]   q_tag,
	input  logic                        result_credit,
	input  logic [div_pkg::DATA_W-1:0]  quot,
	input  logic [div_pkg::DATA_W-1:0]  remd,
	output logic                        q_pop,
	output logic                        d_init,
	output logic                        e_advance,
	output logic                        unsign,
	output logic                        result_valid,
	output logic [div_pkg::TAG_W-1:0]   result_tag,
	output logic [div_pkg::DATA_W-1:0]  result_data
);

	// FSM held as two flags, idle when neither is set
	logic busy;
	logic done;
	logic idle;
	logic [div_pkg::STEP_CNT_W-1:0] step_cnt;
	logic last_step;
	// op and tag of the division in flight
	logic [div_pkg::OP_W-1:0] op_r;
	logic [div_pkg::TAG_W-1:0] tag_r;
	// result slots still granted by the consumer
	logic [credit_pkg::RESULT_CNT_W-1:0] credit_cnt;
	logic has_credit;

	// ####################
	// control decode
	// ####################

	assign idle = ~busy & ~done;
	assign has_credit = (credit_cnt != '0);

	// take the head only if its result has somewhere to go
	assign q_pop = idle & q_valid & has_credit;
	// the pop cycle loads the core
	assign d_init = q_pop;
	assign e_advance = busy;
	assign last_step = (step_cnt == div_pkg::DIV_STEPS - 1'b1);

	// the core samples unsign at d_init, before the op is latched
	assign unsign = idle ? q_op[0] : op_r[0];

	// ####################
	// FSM and step count
	// ####################

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			step_cnt <= '0;
		end else begin
			// done lasts exactly one cycle
			done <= 1'b0;
			if (q_pop) begin
				busy <= 1'b1;
				step_cnt <= '0;
			end else if (busy) begin
				step_cnt <= step_cnt + 1'b1;
				if (last_step) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (q_pop) begin
			op_r <= q_op;
			tag_r <= q_tag;
		end
	end

	// ####################
	// result and credits
	// ####################

	assign result_valid = done;
	assign result_tag = tag_r;
	// high op bit picks the remainder
	assign result_data = op_r[1] ? remd : quot;

	always_ff @(posedge clk) begin
		if (rst) begin
			credit_cnt <= credit_pkg::RESULT_CREDITS;
		end else begin
			// a result and a returned credit in one cycle cancel out
			case ({result_valid, result_credit})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/div_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module div_unit (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        req_valid,
	input  logic [div_pkg::OP_W-1:0]    req_op,
	input  logic [div_pkg::TAG_W-1:0]   req_tag,
	input  logic [div_pkg::DATA_W-1:0]  req_dividend,
	input  logic [div_pkg::DATA_W-1:0]  req_divisor,
	input  logic                        result_credit,
	output logic                        req_credit,
	output logic                        result_valid,
	output logic [div_pkg::TAG_W-1:0]   result_tag,
	output logic [div_pkg::DATA_W-1:0]  result_data
);

	// queue head
	logic q_valid;
	logic q_pop;
	logic [div_pkg::OP_W-1:0] q_op;
	logic [div_pkg::TAG_W-1:0] q_tag;
	logic [div_pkg::DATA_W-1:0] q_dividend;
	logic [div_pkg::DATA_W-1:0] q_divisor;
	// core control and results
	logic d_init;
	logic e_advance;
	logic unsign;
	logic [div_pkg::DATA_W-1:0] quot;
	logic [div_pkg::DATA_W-1:0] remd;

	div_req_queue i_queue (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_op      (req_op),
		.req_tag     (req_tag),
		.req_dividend(req_dividend),
		.req_divisor (req_divisor),
		.q_pop       (q_pop),
		.req_credit  (req_credit),
		.q_valid     (q_valid),
		.q_op        (q_op),
		.q_tag       (q_tag),
		.q_dividend  (q_dividend),
		.q_divisor   (q_divisor)
	);

	div_sequencer i_seq (
		.clk          (clk),
		.rst          (rst),
		.q_valid      (q_valid),
		.q_op         (q_op),
		.q_tag        (q_tag),
		.result_credit(result_credit),
		.quot         (quot),
		.remd         (remd),
		.q_pop        (q_pop),
		.d_init       (d_init),
		.e_advance    (e_advance),
		.unsign       (unsign),
		.result_valid (result_valid),
		.result_tag   (result_tag),
		.result_data  (result_data)
	);

	// operands go from the queue head straight into the core
	div_radix4_core i_core (
		.clk      (clk),
		.dividend (q_dividend),
		.divisor  (q_divisor),
		.unsign   (unsign),
		.d_init   (d_init),
		.e_advance(e_advance),
		.quot     (quot),
		.remd     (remd)
	);

endmodule

`default_nettype wire

/* bench/div_unit_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module div_unit_properties (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input logic req_credit,
	input logic result_valid,
	input logic q_valid,
	input logic q_pop
);

	// requests sitting in the queue, counted from push and pop strobes
	logic [credit_pkg::REQ_PTR_W+1:0] queued;

	always_ff @(posedge clk) begin
		if (rst)
			queued <= '0;
		else
			queued <= queued + (credit_pkg::REQ_PTR_W+2)'(req_valid)
				- (credit_pkg::REQ_PTR_W+2)'(q_pop & q_valid);
	end

	// both channels use single-cycle pulses
	result_pulse: assert property (@(posedge clk) disable iff (rst)
		result_valid |=> !result_valid)
		else $error("result_valid high in two consecutive cycles");

	credit_pulse: assert property (@(posedge clk) disable iff (rst)
		req_credit |=> !req_credit)
		else $error("req_credit high in two consecutive cycles");

	// a sender that respects its credits can never overfill the queue
	queue_bound: assert property (@(posedge clk) disable iff (rst)
		queued <= credit_pkg::REQ_DEPTH)
		else $error("more requests queued than the queue holds");

	// one reset edge is enough to clear both strobes
	quiet_in_reset: assert property (@(posedge clk)
		rst && $past(rst) |-> !result_valid && !req_credit)
		else $error("result_valid or req_credit high during reset");

endmodule

`default_nettype wire

/* bench/div_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module div_unit_tb;

	// longest any single wait may take, in cycles
	localparam int TIMEOUT = 200;

	logic clk;
	logic rst;
	logic req_valid;
	logic [div_pkg::OP_W-1:0] req_op;
	logic [div_pkg::TAG_W-1:0] req_tag;
	logic [div_pkg::DATA_W-1:0] req_dividend;
	logic [div_pkg::DATA_W-1:0] req_divisor;
	logic result_credit;
	logic req_credit;
	logic result_valid;
	logic [div_pkg::TAG_W-1:0] result_tag;
	logic [div_pkg::DATA_W-1:0] result_data;

	// scoreboard, oldest request at the front
	logic [div_pkg::TAG_W-1:0] exp_tag [$];
	logic [div_pkg::DATA_W-1:0] exp_val [$];
	int send_credits;
	int credits_back;
	int results_seen;
	// result credits owed to the DUT, kept back while hold_credits is set
	int owed;
	logic hold_credits;
	logic [31:0] lfsr;
	logic [div_pkg::TAG_W-1:0] next_tag;

	div_unit i_div_unit (
		.clk          (clk),
		.rst          (rst),
		.req_valid    (req_valid),
		.req_op       (req_op),
		.req_tag      (req_tag),
		.req_dividend (req_dividend),
		.req_divisor  (req_divisor),
		.result_credit(result_credit),
		.req_credit   (req_credit),
		.result_valid (result_valid),
		.result_tag   (result_tag),
		.result_data  (result_data)
	);

	bind div_unit div_unit_properties i_div_unit_properties (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_credit  (req_credit),
		.result_valid(result_valid),
		.q_valid     (q_valid),
		.q_pop       (q_pop)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ####################
	// helpers
	// ####################

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	// x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// truncating division, remainder follows the dividend sign
	function automatic logic [div_pkg::DATA_W-1:0] reference_result(
		input logic [div_pkg::OP_W-1:0] op,
		input logic [div_pkg::DATA_W-1:0] a,
		input logic [div_pkg::DATA_W-1:0] b
	);
		logic signed [div_pkg::DATA_W-1:0] sa;
		logic signed [div_pkg::DATA_W-1:0] sb;
		sa = a;
		sb = b;
		case (op)
			div_pkg::OP_DIV: return sa / sb;
			div_pkg::OP_DIVU: return a / b;
			div_pkg::OP_REM: return sa % sb;
			div_pkg::OP_REMU: return a % b;
			default: return '0;
		endcase
	endfunction

	task automatic check_result();
		logic [div_pkg::TAG_W-1:0] tag;
		logic [div_pkg::DATA_W-1:0] val;
		assert (exp_tag.size() != 0)
			else abort_run("a result arrived with no request outstanding");
		tag = exp_tag.pop_front();
		val = exp_val.pop_front();
		assert (result_tag === tag)
			else abort_run($sformatf("FAILED result_tag: got %h expected %h", result_tag, tag));
		assert (result_data === val)
			else abort_run($sformatf("FAILED result_data: got %h expected %h",
				result_data, val));
	endtask

	// outputs come from registers, so mid-cycle they are settled
	always @(negedge clk) begin
		if (rst) begin
			result_credit = 1'b0;
		end else begin
			if (req_credit) begin
				send_credits++;
				credits_back++;
			end
			if (result_valid) begin
				check_result();
				results_seen++;
				owed++;
			end
			// at most one credit back per cycle
			if (!hold_credits && owed > 0) begin
				result_credit = 1'b1;
				owed--;
			end else begin
				result_credit = 1'b0;
			end
		end
	end

	// offer one request on the next falling edge that finds a credit
	task automatic send_req(
		input logic [div_pkg::OP_W-1:0] op,
		input logic [div_pkg::DATA_W-1:0] a,
		input logic [div_pkg::DATA_W-1:0] b
	);
		int waited;
		waited = 0;
		@(negedge clk);
		while (send_credits == 0) begin
			req_valid = 1'b0;
			if (waited == TIMEOUT)
				abort_run("timed out waiting for a request credit");
			waited++;
			@(negedge clk);
		end
		req_valid = 1'b1;
		req_op = op;
		req_tag = next_tag;
		req_dividend = a;
		req_divisor = b;
		send_credits--;
		exp_tag.push_back(next_tag);
		exp_val.push_back(reference_result(op, a, b));
		next_tag++;
	endtask

	// stop sending, then wait for every result and every credit
	task automatic drain();
		int waited;
		waited = 0;
		@(negedge clk);
		req_valid = 1'b0;
		while (exp_tag.size() != 0 || owed != 0 || send_credits != credit_pkg::REQ_DEPTH) begin
			if (waited == TIMEOUT)
				abort_run("timed out waiting for outstanding results and credits");
			waited++;
			@(negedge clk);
		end
	endtask

	// ####################
	// tests
	// ####################

	task automatic test_unsigned();
		logic [31:0] a [6] = '{32'd5, 32'd12345, 32'hffffffff, 32'hffffffff, 32'd1000,
			32'hc0000000};
		logic [31:0] b [6] = '{32'd7, 32'd1, 32'd3, 32'd10, 32'd25, 32'h40000000};
		for (int i = 0; i < 6; i++) begin
			send_req(div_pkg::OP_DIVU, a[i], b[i]);
			send_req(div_pkg::OP_REMU, a[i], b[i]);
		end
		drain();
	endtask

	task automatic test_signed();
		logic [31:0] a [6] = '{32'sd7, -32'sd7, 32'sd7, -32'sd7, 32'sd0, -32'sd12};
		logic [31:0] b [6] = '{32'sd2, 32'sd2, -32'sd2, -32'sd2, -32'sd5, 32'sd4};
		for (int i = 0; i < 6; i++) begin
			send_req(div_pkg::OP_DIV, a[i], b[i]);
			send_req(div_pkg::OP_REM, a[i], b[i]);
		end
		drain();
	endtask

	task automatic test_burst();
		int credits0;
		credits0 = credits_back;
		// four sends in a row, all on the initial credits
		send_req(div_pkg::OP_DIV, -32'sd100, 32'sd7);
		send_req(div_pkg::OP_DIVU, 32'hffff0000, 32'h1234);
		send_req(div_pkg::OP_REM, -32'sd100, 32'sd7);
		send_req(div_pkg::OP_REMU, 32'd1000003, 32'd97);
		drain();
		// a stray credit would show up within one division time
		repeat (20) @(negedge clk);
		assert (credits_back - credits0 == 4)
			else abort_run("burst did not return exactly four request credits");
	endtask

	task automatic test_backpressure();
		int seen0;
		int waited;
		hold_credits = 1'b1;
		seen0 = results_seen;
		for (int i = 0; i < 6; i++)
			send_req(div_pkg::OP_W'(i), 32'd900 + 32'(i), 32'd7 + 32'(i));
		// the last request lasts a single cycle
		@(negedge clk);
		req_valid = 1'b0;
		waited = 0;
		while (results_seen - seen0 < credit_pkg::RESULT_CREDITS) begin
			if (waited == TIMEOUT)
				abort_run("timed out waiting for the granted results");
			waited++;
			@(negedge clk);
		end
		// long enough for another division to finish if one were allowed
		repeat (60) @(negedge clk);
		assert (results_seen - seen0 == credit_pkg::RESULT_CREDITS)
			else abort_run("results appeared without result credits");
		assert (send_credits == 0)
			else abort_run("request credits came back while the queue was full");
		hold_credits = 1'b0;
		drain();
	endtask

	task automatic test_random();
		logic [div_pkg::OP_W-1:0] op;
		logic [31:0] a;
		logic [31:0] b;
		int sent;
		sent = 0;
		while (sent < 50) begin
			op = div_pkg::OP_W'(rand_bits(2));
			a = rand_bits(32);
			// random shift spreads the quotient sizes
			b = rand_bits(32) >> rand_bits(5);
			while (b == 0)
				b = rand_bits(32) >> rand_bits(5);
			// most negative over minus one is not a legal request
			if (!(!op[0] && a == 32'h80000000 && b == 32'hffffffff)) begin
				send_req(op, a, b);
				sent++;
			end
		end
		drain();
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_op = '0;
		req_tag = '0;
		req_dividend = '0;
		req_divisor = '0;
		result_credit = 1'b0;
		hold_credits = 1'b0;
		send_credits = credit_pkg::REQ_DEPTH;
		credits_back = 0;
		results_seen = 0;
		owed = 0;
		lfsr = 32'hf692;
		next_tag = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		test_unsigned();
		test_signed();
		test_burst();
		test_backpressure();
		test_random();
		if (exp_tag.size() == 0 && results_seen == 84) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			abort_run("run ended with results missing");
		end
	end

endmodule

`default_nettype wire

/* build.f */
src/div_pkg.sv
src/credit_pkg.sv
src/div_req_queue.sv
src/div_radix4_core.sv
src/div_sequencer.sv
src/div_unit.sv
bench/div_unit_properties.sv
bench/div_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the div_unit testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
	--top-module div_unit_tb \
	--Mdir obj_dir \
	-o div_unit_sim \
	-f build.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "build failed with status $build_status"
	exit "$build_status"
fi

./obj_dir/div_unit_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
	echo "simulation failed with status $sim_status"
	exit "$sim_status"
fi

exit 0
